// File: filelist.f
source/gt_link_pkg.sv
source/chain_reset.sv
source/cdr_lock_filter.sv
source/tx_idle_insert.sv
source/rx_symbol_decode.sv
source/rx_error_result.sv
source/gt_link_top.sv
sim/gt_link_checker.sv
sim/gt_link_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the link testbench with Verilator, runs it and scans the log for the result

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=gt_link_sim

verilator --binary --timing --assert -Wno-fatal \
	--top-module gt_link_tb -f filelist.f -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+100 > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qxF '** PASS **' "$LOG_FILE"; then
	echo "Simulation result: passed"
	exit 0
else
	echo "Simulation result: failed, see $LOG_FILE"
	exit 1
fi

// File: sim/gt_link_checker.sv
`timescale 1ns/1ps

module gt_link_checker (
	input  logic RXUSRCLK,
	input  logic reset,
	input  logic [gt_link_pkg::NSTEP-1:0] step_reset_i,
	input  logic reset_done_i,
	input  logic rx_valid_i,
	input  logic locked_i
);

	int fire_cnt = 0; // Number of failed assertions so far

	// The sequencer runs the steps strictly one after another
	a_one_step: assert property (@(posedge RXUSRCLK) disable iff (reset)
		$onehot0(step_reset_i))
		else begin
			$error("More than one step reset is high");
			fire_cnt++;
		end

	a_done_holds: assert property (@(posedge RXUSRCLK) disable iff (reset)
		!$fell(reset_done_i))
		else begin
			$error("reset_done_o fell while reset was low");
			fire_cnt++;
		end

	// A valid beat was captured under CDR lock and is still held under it
	a_valid_locked: assert property (@(posedge RXUSRCLK) disable iff (reset)
		rx_valid_i |-> locked_i && $past(locked_i))
		else begin
			$error("rx_valid_o is high without CDR lock");
			fire_cnt++;
		end

endmodule

bind gt_link_top gt_link_checker u_checker (
	.RXUSRCLK(RXUSRCLK),
	.reset(reset),
	.step_reset_i(step_reset),
	.reset_done_i(reset_done_o),
	.rx_valid_i(rx_valid_o),
	.locked_i(locked_o)
);

// File: sim/gt_link_tb.sv
`timescale 1ns/1ps

module gt_link_tb;

	localparam int DWIDTH = 16;
	localparam int DBYTE = DWIDTH / 8;
	localparam int NROWS = 14;

	// One phase of the run, its inputs and what the DUT must show at its end
	typedef struct packed {
		bit do_rst;
		bit pll_lock;
		bit rst_done;
		bit cdr_lock;
		bit [3:0] mask;
		bit clr;
		bit [63:0] rxd;
		bit [7:0] rxk;
		bit [7:0] derr;
		bit [7:0] nit;
		int ncyc;
		int tx_mode; // 0 comma every cycle, 1 user data every cycle, 2 unchecked
		bit exp_done;
		bit exp_lock;
		int exp_pll; // Rising edges of pll_reset_o within the phase
		int exp_txrx; // Rising edges of txrx_reset_o within the phase
		bit [3:0] exp_steps;
		int d_dcnt;
		int d_ncnt;
	} row_t;

	logic RXUSRCLK;
	logic reset;
	logic pll_lock_i;
	logic fbclk_lost_i;
	logic refclk_lost_i;
	logic tx_reset_done_i;
	logic rx_reset_done_i;
	logic cdr_lock_i;
	logic [3:0] mask_i;
	logic tx_userrdy_i;
	logic rx_userrdy_i;
	logic [DWIDTH-1:0] tx_data_i;
	logic [DBYTE-1:0] tx_charisk_i;
	logic [63:0] gt_rxdata_i;
	logic [7:0] gt_rxcharisk_i;
	logic [7:0] gt_rxdisperr_i;
	logic [7:0] gt_rxnotintable_i;
	logic err_clear_i;
	logic pll_reset_o;
	logic txrx_reset_o;
	logic reset_done_o;
	logic [3:0] done_o;
	logic locked_o;
	logic rx_userrdy_o;
	logic [63:0] gt_txdata_o;
	logic [7:0] gt_txcharisk_o;
	logic [DWIDTH-1:0] rx_data_o;
	logic [DBYTE-1:0] rx_charisk_o;
	logic [DBYTE-1:0] rx_disperr_o;
	logic [DBYTE-1:0] rx_notintable_o;
	logic rx_comma_o;
	logic rx_valid_o;
	logic [15:0] disperr_cnt_o;
	logic [15:0] notintable_cnt_o;

	row_t rows [NROWS];
	string names [NROWS];
	integer seed;
	int err_cnt;
	int fail_tests;
	int cyc_cnt;
	int limit;
	logic [15:0] exp_dcnt;
	logic [15:0] exp_ncnt;

	gt_link_top #(
		.DWIDTH(DWIDTH),
		.RESET_LEN(4),
		.CHECK_DELAY(2),
		.READY_LEN(3),
		.TIMEOUT(40),
		.LOCK_MAX(3)
	) dut_i (.*);

	initial begin
		RXUSRCLK = 1'b0;
		forever #50 RXUSRCLK = ~RXUSRCLK;
	end

	// Watchdog
	always @(posedge RXUSRCLK) begin
		cyc_cnt++;
		if (cyc_cnt > limit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", limit);
			$display("** FAIL **");
			$finish;
		end
	end

	////////////////////////////////////////
	// Checks and phases
	////////////////////////////////////////

	task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic run_row(input int r);
		row_t w;
		int errs0;
		int pulses;
		int txrx_pulses;
		logic prev_pll;
		logic prev_txrx;
		logic [DWIDTH-1:0] tx_word;
		logic [DBYTE-1:0] tx_k;
		w = rows[r];
		errs0 = err_cnt;
		if (w.do_rst) begin
			reset = 1'b1;
		end
		pll_lock_i = w.pll_lock;
		tx_reset_done_i = w.rst_done;
		rx_reset_done_i = w.rst_done;
		cdr_lock_i = w.cdr_lock;
		mask_i = w.mask;
		err_clear_i = w.clr;
		gt_rxdata_i = w.rxd;
		gt_rxcharisk_i = w.rxk;
		gt_rxdisperr_i = w.derr;
		gt_rxnotintable_i = w.nit;
		if (w.do_rst) begin
			repeat (2) @(posedge RXUSRCLK);
			#1 reset = 1'b0;
			exp_dcnt = '0;
			exp_ncnt = '0;
		end
		pulses = 0;
		txrx_pulses = 0;
		prev_pll = pll_reset_o;
		prev_txrx = txrx_reset_o;
		for (int c = 0; c < w.ncyc; c++) begin
			tx_word = DWIDTH'($random(seed));
			tx_k = DBYTE'($random(seed));
			tx_data_i = tx_word;
			tx_charisk_i = tx_k;
			@(posedge RXUSRCLK);
			#1;
			if (pll_reset_o && !prev_pll) begin
				pulses++;
			end
			prev_pll = pll_reset_o;
			if (txrx_reset_o && !prev_txrx) begin
				txrx_pulses++;
			end
			prev_txrx = txrx_reset_o;
			if (w.tx_mode == 0) begin
				compare(gt_txdata_o, 64'h0000_0000_0000_00BC, "gt_txdata_o idle");
				compare(gt_txcharisk_o, 8'h01, "gt_txcharisk_o idle");
			end else if (w.tx_mode == 1) begin
				compare(gt_txdata_o, {48'h0, tx_word}, "gt_txdata_o");
				compare(gt_txcharisk_o, {6'h0, tx_k}, "gt_txcharisk_o");
			end
		end
		if (w.clr) begin
			exp_dcnt = '0;
			exp_ncnt = '0;
		end else begin
			exp_dcnt = exp_dcnt + 16'(w.d_dcnt);
			exp_ncnt = exp_ncnt + 16'(w.d_ncnt);
		end
		compare(reset_done_o, w.exp_done, "reset_done_o");
		compare(done_o, w.exp_steps, "done_o");
		compare(locked_o, w.exp_lock, "locked_o");
		compare(rx_userrdy_o, w.exp_lock, "rx_userrdy_o");
		compare(rx_valid_o, w.exp_done & w.exp_lock, "rx_valid_o");
		compare(pulses, w.exp_pll, "pll_reset_o pulse count");
		compare(txrx_pulses, w.exp_txrx, "txrx_reset_o pulse count");
		compare(rx_data_o, w.rxd[15:0], "rx_data_o");
		compare(rx_charisk_o, w.rxk[1:0], "rx_charisk_o");
		compare(rx_disperr_o, w.derr[1:0], "rx_disperr_o");
		compare(rx_notintable_o, w.nit[1:0], "rx_notintable_o");
		compare(rx_comma_o, (w.rxd[7:0] == 8'hBC) && w.rxk[0], "rx_comma_o");
		compare(disperr_cnt_o, exp_dcnt, "disperr_cnt_o");
		compare(notintable_cnt_o, exp_ncnt, "notintable_cnt_o");
		if (err_cnt == errs0) begin
			$display("Test %0d %s: ok", r, names[r]);
		end else begin
			$display("Test %0d %s: %0d mismatches", r, names[r], err_cnt - errs0);
			fail_tests++;
		end
	endtask

	initial begin
		reset = 1'b1;
		pll_lock_i = 1'b0;
		fbclk_lost_i = 1'b0;
		refclk_lost_i = 1'b0;
		tx_reset_done_i = 1'b0;
		rx_reset_done_i = 1'b0;
		cdr_lock_i = 1'b0;
		mask_i = 4'hF;
		tx_userrdy_i = 1'b1;
		rx_userrdy_i = 1'b1;
		tx_data_i = '0;
		tx_charisk_i = '0;
		gt_rxdata_i = '0;
		gt_rxcharisk_i = '0;
		gt_rxdisperr_i = '0;
		gt_rxnotintable_i = '0;
		err_clear_i = 1'b0;
		seed = 36406;
		err_cnt = 0;
		fail_tests = 0;
		cyc_cnt = 0;
		exp_dcnt = '0;
		exp_ncnt = '0;

		//        rst pll rd cdr mask clr rx data                 k      derr   nit
		//        ncyc tx done lock pll_pulses txrx_pulses steps d_disperr d_notintable
		rows[0] = '{1, 1, 1, 1, 4'hF, 0, 64'h7E00_0000_0000_56BC, 8'h81, 8'h83, 8'h41,
			38, 0, 0, 1, 1, 2, 4'h7, 0, 0};
		rows[1] = '{0, 1, 1, 1, 4'hF, 0, 64'h0, 8'h00, 8'h00, 8'h00,
			6, 2, 1, 1, 0, 0, 4'hF, 0, 0};
		rows[2] = '{0, 1, 1, 1, 4'hF, 0, 64'hFFEE_DDCC_BBAA_9988, 8'hF2, 8'hF3, 8'h0D,
			5, 1, 1, 1, 0, 0, 4'hF, 8, 4};
		rows[3] = '{0, 1, 1, 1, 4'hF, 1, 64'h0000_0000_0000_00BC, 8'h00, 8'h00, 8'h00,
			3, 1, 1, 1, 0, 0, 4'hF, 0, 0};
		rows[4] = '{0, 1, 1, 1, 4'hF, 0, 64'h1111_2222_3333_BCBC, 8'h03, 8'h02, 8'h00,
			4, 1, 1, 1, 0, 0, 4'hF, 3, 0};
		rows[5] = '{0, 1, 1, 0, 4'hF, 0, 64'h0123_4567_89AB_CDEF, 8'h00, 8'h00, 8'h00,
			3, 1, 1, 1, 0, 0, 4'hF, 1, 0};
		rows[6] = '{0, 1, 1, 1, 4'hF, 0, 64'h0123_4567_89AB_CDEF, 8'h00, 8'h00, 8'h00,
			4, 1, 1, 1, 0, 0, 4'hF, 0, 0};
		rows[7] = '{0, 1, 1, 0, 4'hF, 0, 64'h0123_4567_89AB_CDEF, 8'h00, 8'h00, 8'h00,
			4, 1, 1, 0, 0, 0, 4'hF, 0, 0};
		rows[8] = '{0, 1, 1, 0, 4'hF, 0, 64'hDEAD_BEEF_0000_5A5A, 8'h00, 8'h03, 8'h03,
			4, 1, 1, 0, 0, 0, 4'hF, 0, 0};
		rows[9] = '{0, 1, 1, 1, 4'hF, 0, 64'h0, 8'h00, 8'h00, 8'h00,
			4, 1, 1, 1, 0, 0, 4'hF, 0, 0};
		rows[10] = '{1, 0, 1, 1, 4'hF, 0, 64'h0, 8'h00, 8'h00, 8'h00,
			100, 0, 0, 1, 3, 0, 4'h0, 0, 0};
		rows[11] = '{0, 1, 1, 1, 4'hF, 0, 64'h0, 8'h00, 8'h00, 8'h00,
			40, 2, 1, 1, 0, 2, 4'hF, 0, 0};
		rows[12] = '{1, 0, 1, 1, 4'hE, 0, 64'h0, 8'h00, 8'h00, 8'h00,
			12, 0, 0, 1, 0, 1, 4'h1, 0, 0};
		rows[13] = '{0, 1, 1, 1, 4'hE, 0, 64'h0, 8'h00, 8'h00, 8'h00,
			34, 2, 1, 1, 0, 1, 4'hF, 0, 0};
		names = '{"sequence start", "sequence done", "tx data and rx errors", "error clear",
			"comma beats", "short cdr drop", "cdr relock", "long cdr drop",
			"unlocked beats", "cdr lock back", "pll lock lost", "pll lock restored",
			"masked pll step", "masked sequence done"};

		limit = 20;
		for (int r = 0; r < NROWS; r++) begin
			limit += rows[r].ncyc + 2;
		end

		for (int r = 0; r < NROWS; r++) begin
			run_row(r);
		end

		$display("Summary: %0d tests, %0d failed, %0d mismatches, %0d assertion failures",
			NROWS, fail_tests, err_cnt, dut_i.u_checker.fire_cnt);
		if (err_cnt == 0 && dut_i.u_checker.fire_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: source/cdr_lock_filter.sv
`timescale 1ns/1ps

module cdr_lock_filter #(
	parameter int LOCK_MAX = 3
) (
	input  logic RXUSRCLK,
	input  logic reset,
	input  logic cdr_lock_i,
	output logic locked_o
);

	localparam int UW = (LOCK_MAX > 0) ? $clog2(LOCK_MAX + 1) : 1;

	logic [UW-1:0] unlock_cnt; // Consecutive cycles without CDR lock

	// Short lock drops are ignored so the link is not torn down by glitches
	always_ff @(posedge RXUSRCLK or posedge reset) begin
		if (reset) begin
			unlock_cnt <= '0;
			locked_o <= 1'b0;
		end else if (cdr_lock_i) begin
			unlock_cnt <= '0;
			locked_o <= 1'b1;
		end else if (unlock_cnt == UW'(LOCK_MAX)) begin
			locked_o <= 1'b0; // Drop lasted past the limit
		end else begin
			unlock_cnt <= unlock_cnt + 1'b1;
		end
	end

endmodule

// File: source/chain_reset.sv
`timescale 1ns/1ps

module chain_reset #(
	parameter int NSTEP = 4,
	parameter int RESET_LEN = 100,
	parameter int CHECK_DELAY = 10,
	parameter int READY_LEN = 10,
	parameter int TIMEOUT = 4096
) (
	input  logic RXUSRCLK,
	input  logic reset,
	input  logic [NSTEP-1:0] criteria_i,
	output logic [NSTEP-1:0] reset_o,
	output logic [NSTEP-1:0] done_o
);

	localparam int MAX_A = (TIMEOUT > RESET_LEN) ? TIMEOUT : RESET_LEN;
	localparam int CNT_MAX = (MAX_A > CHECK_DELAY) ? MAX_A : CHECK_DELAY;
	localparam int CW = $clog2(CNT_MAX + 1);
	localparam int RW = $clog2(READY_LEN + 1);
	localparam int SW = (NSTEP > 1) ? $clog2(NSTEP) : 1;

	typedef enum logic [2:0] {
		PH_START,
		PH_HOLD,
		PH_DELAY,
		PH_WAIT,
		PH_DONE
	} phase_t;

	phase_t phase;
	logic [SW-1:0] step; // Index of the step in progress
	logic [CW-1:0] cycle_cnt; // Shared by hold, check delay and timeout
	logic [RW-1:0] ready_cnt; // Run of consecutive good criterion cycles

	always_ff @(posedge RXUSRCLK or posedge reset) begin
		if (reset) begin
			phase <= PH_START;
			step <= '0;
			cycle_cnt <= '0;
			ready_cnt <= '0;
			reset_o <= '0;
			done_o <= '0;
		end else begin
			case (phase)
				PH_START: begin
					reset_o[step] <= 1'b1;
					cycle_cnt <= '0;
					ready_cnt <= '0;
					phase <= PH_HOLD;
				end
				PH_HOLD: begin
					if (cycle_cnt == CW'(RESET_LEN - 1)) begin
						reset_o[step] <= 1'b0;
						cycle_cnt <= '0; // Timeout is measured from here
						phase <= PH_DELAY;
					end else begin
						cycle_cnt <= cycle_cnt + 1'b1;
					end
				end
				PH_DELAY: begin
					cycle_cnt <= cycle_cnt + 1'b1;
					if (cycle_cnt == CW'(CHECK_DELAY - 1)) begin
						phase <= PH_WAIT;
					end
				end
				PH_WAIT: begin
					cycle_cnt <= cycle_cnt + 1'b1;
					if (criteria_i[step] && ready_cnt == RW'(READY_LEN - 1)) begin
						done_o[step] <= 1'b1;
						if (step == SW'(NSTEP - 1)) begin
							phase <= PH_DONE;
						end else begin
							step <= step + 1'b1;
							phase <= PH_START;
						end
					end else if (cycle_cnt == CW'(TIMEOUT - 1)) begin
						phase <= PH_START; // Criterion never settled, run this step again
					end else if (criteria_i[step]) begin
						ready_cnt <= ready_cnt + 1'b1;
					end else begin
						ready_cnt <= '0;
					end
				end
				default: begin
					// All steps done, stay here until reset
				end
			endcase
		end
	end

endmodule

// File: source/gt_link_pkg.sv
package gt_link_pkg;

	////////////////////////////////////////
	// Raw transceiver bus
	////////////////////////////////////////

	localparam int RAW_WIDTH = 64; // Full parallel data width of the channel
	localparam int RAW_BYTES = 8; // One flag bit per raw byte

	// K28.5, sent in byte 0 while the link is idle
	localparam logic [7:0] COMMA_CODE = 8'hBC;

	////////////////////////////////////////
	// Reset sequence
	////////////////////////////////////////

	localparam int NSTEP = 4;

	localparam int STEP_PLL = 0; // PLL reset, done on PLL lock without clock loss
	localparam int STEP_TXRX0 = 1; // First TX/RX reset pass
	localparam int STEP_TXRX1 = 2; // Second TX/RX reset pass
	localparam int STEP_ALIGN = 3; // Align step, no status to wait for

	////////////////////////////////////////
	// Error statistics
	////////////////////////////////////////

	localparam int CNT_WIDTH = 16;

endpackage

// File: source/gt_link_top.sv
`timescale 1ns/1ps

module gt_link_top #(
	parameter int DWIDTH = 16,
	parameter int RESET_LEN = 100,
	parameter int CHECK_DELAY = 10,
	parameter int READY_LEN = 10,
	parameter int TIMEOUT = 4096,
	parameter int LOCK_MAX = 3,
	localparam int DBYTE = DWIDTH / 8
) (
	input  logic RXUSRCLK,
	input  logic reset,
	input  logic pll_lock_i,
	input  logic fbclk_lost_i,
	input  logic refclk_lost_i,
	input  logic tx_reset_done_i,
	input  logic rx_reset_done_i,
	input  logic cdr_lock_i,
	input  logic [gt_link_pkg::NSTEP-1:0] mask_i,
	input  logic tx_userrdy_i,
	input  logic rx_userrdy_i,
	input  logic [DWIDTH-1:0] tx_data_i,
	input  logic [DBYTE-1:0] tx_charisk_i,
	input  logic [gt_link_pkg::RAW_WIDTH-1:0] gt_rxdata_i,
	input  logic [gt_link_pkg::RAW_BYTES-1:0] gt_rxcharisk_i,
	input  logic [gt_link_pkg::RAW_BYTES-1:0] gt_rxdisperr_i,
	input  logic [gt_link_pkg::RAW_BYTES-1:0] gt_rxnotintable_i,
	input  logic err_clear_i,
	output logic pll_reset_o,
	output logic txrx_reset_o,
	output logic reset_done_o,
	output logic [gt_link_pkg::NSTEP-1:0] done_o,
	output logic locked_o,
	output logic rx_userrdy_o,
	output logic [gt_link_pkg::RAW_WIDTH-1:0] gt_txdata_o,
	output logic [gt_link_pkg::RAW_BYTES-1:0] gt_txcharisk_o,
	output logic [DWIDTH-1:0] rx_data_o,
	output logic [DBYTE-1:0] rx_charisk_o,
	output logic [DBYTE-1:0] rx_disperr_o,
	output logic [DBYTE-1:0] rx_notintable_o,
	output logic rx_comma_o,
	output logic rx_valid_o,
	output logic [gt_link_pkg::CNT_WIDTH-1:0] disperr_cnt_o,
	output logic [gt_link_pkg::CNT_WIDTH-1:0] notintable_cnt_o
);

	localparam int NSTEP = gt_link_pkg::NSTEP;

	logic pll_ok;
	logic txrx_done;
	logic [NSTEP-1:0] criteria;
	logic [NSTEP-1:0] chain_reset_out;
	logic [NSTEP-1:0] step_reset; // Step resets after the mask
	logic link_ready;

	////////////////////////////////////////
	// Reset sequence
	////////////////////////////////////////

	assign pll_ok = pll_lock_i & ~fbclk_lost_i & ~refclk_lost_i;
	assign txrx_done = tx_reset_done_i & rx_reset_done_i & pll_ok;

	// A masked step is skipped, so its criterion counts as met
	always_comb begin
		criteria[gt_link_pkg::STEP_PLL] = pll_ok;
		criteria[gt_link_pkg::STEP_TXRX0] = txrx_done;
		criteria[gt_link_pkg::STEP_TXRX1] = txrx_done;
		criteria[gt_link_pkg::STEP_ALIGN] = 1'b1;
		criteria = criteria | ~mask_i;
	end

	chain_reset #(
		.NSTEP(NSTEP),
		.RESET_LEN(RESET_LEN),
		.CHECK_DELAY(CHECK_DELAY),
		.READY_LEN(READY_LEN),
		.TIMEOUT(TIMEOUT)
	) u_chain_reset (
		.RXUSRCLK(RXUSRCLK),
		.reset(reset),
		.criteria_i(criteria),
		.reset_o(chain_reset_out),
		.done_o(done_o)
	);

	assign step_reset = chain_reset_out & mask_i;
	assign pll_reset_o = step_reset[gt_link_pkg::STEP_PLL];
	assign txrx_reset_o = step_reset[gt_link_pkg::STEP_TXRX0] | step_reset[gt_link_pkg::STEP_TXRX1];
	assign reset_done_o = &done_o & txrx_done;

	cdr_lock_filter #(
		.LOCK_MAX(LOCK_MAX)
	) u_cdr_lock_filter (
		.RXUSRCLK(RXUSRCLK),
		.reset(reset),
		.cdr_lock_i(cdr_lock_i),
		.locked_o(locked_o)
	);

	assign rx_userrdy_o = rx_userrdy_i & locked_o;

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	assign link_ready = reset_done_o & locked_o;

	tx_idle_insert #(
		.DWIDTH(DWIDTH)
	) u_tx_idle_insert (
		.RXUSRCLK(RXUSRCLK),
		.reset(reset),
		.link_ready_i(reset_done_o & tx_userrdy_i), // User data only once TX user side is up
		.tx_data_i(tx_data_i),
		.tx_charisk_i(tx_charisk_i),
		.gt_txdata_o(gt_txdata_o),
		.gt_txcharisk_o(gt_txcharisk_o)
	);

	rx_symbol_decode #(
		.DWIDTH(DWIDTH)
	) u_rx_symbol_decode (
		.RXUSRCLK(RXUSRCLK),
		.reset(reset),
		.link_ready_i(link_ready),
		.gt_rxdata_i(gt_rxdata_i),
		.gt_rxcharisk_i(gt_rxcharisk_i),
		.gt_rxdisperr_i(gt_rxdisperr_i),
		.gt_rxnotintable_i(gt_rxnotintable_i),
		.rx_data_o(rx_data_o),
		.rx_charisk_o(rx_charisk_o),
		.rx_disperr_o(rx_disperr_o),
		.rx_notintable_o(rx_notintable_o),
		.rx_comma_o(rx_comma_o),
		.rx_valid_o(rx_valid_o)
	);

	rx_error_result #(
		.DWIDTH(DWIDTH)
	) u_rx_error_result (
		.RXUSRCLK(RXUSRCLK),
		.reset(reset),
		.valid_i(rx_valid_o),
		.disperr_i(rx_disperr_o),
		.notintable_i(rx_notintable_o),
		.clear_i(err_clear_i),
		.disperr_cnt_o(disperr_cnt_o),
		.notintable_cnt_o(notintable_cnt_o)
	);

endmodule

// File: source/rx_error_result.sv
`timescale 1ns/1ps

module rx_error_result #(
	parameter int DWIDTH = 16
) (
	input  logic RXUSRCLK,
	input  logic reset,
	input  logic valid_i,
	input  logic [DWIDTH/8-1:0] disperr_i,
	input  logic [DWIDTH/8-1:0] notintable_i,
	input  logic clear_i,
	output logic [gt_link_pkg::CNT_WIDTH-1:0] disperr_cnt_o,
	output logic [gt_link_pkg::CNT_WIDTH-1:0] notintable_cnt_o
);

	localparam int DBYTE = DWIDTH / 8;
	localparam int CW = gt_link_pkg::CNT_WIDTH;

	// Adds the number of set flags and sticks at all ones
	function automatic logic [CW-1:0] sat_add(
		input logic [CW-1:0] cnt,
		input logic [DBYTE-1:0] flags
	);
		logic [CW:0] sum;
		sum = {1'b0, cnt};
		for (int i = 0; i < DBYTE; i++) begin
			sum = sum + flags[i];
		end
		if (sum[CW]) begin
			return '1;
		end
		return sum[CW-1:0];
	endfunction

	always_ff @(posedge RXUSRCLK or posedge reset) begin
		if (reset) begin
			disperr_cnt_o <= '0;
			notintable_cnt_o <= '0;
		end else if (clear_i) begin
			disperr_cnt_o <= '0; // Clear wins over a beat in the same cycle
			notintable_cnt_o <= '0;
		end else if (valid_i) begin
			disperr_cnt_o <= sat_add(disperr_cnt_o, disperr_i);
			notintable_cnt_o <= sat_add(notintable_cnt_o, notintable_i);
		end
	end

endmodule

// File: source/rx_symbol_decode.sv
`timescale 1ns/1ps

module rx_symbol_decode #(
	parameter int DWIDTH = 16
) (
	input  logic RXUSRCLK,
	input  logic reset,
	input  logic link_ready_i,
	input  logic [gt_link_pkg::RAW_WIDTH-1:0] gt_rxdata_i,
	input  logic [gt_link_pkg::RAW_BYTES-1:0] gt_rxcharisk_i,
	input  logic [gt_link_pkg::RAW_BYTES-1:0] gt_rxdisperr_i,
	input  logic [gt_link_pkg::RAW_BYTES-1:0] gt_rxnotintable_i,
	output logic [DWIDTH-1:0] rx_data_o,
	output logic [DWIDTH/8-1:0] rx_charisk_o,
	output logic [DWIDTH/8-1:0] rx_disperr_o,
	output logic [DWIDTH/8-1:0] rx_notintable_o,
	output logic rx_comma_o,
	output logic rx_valid_o
);

	localparam int DBYTE = DWIDTH / 8;

	logic comma_det;
	logic valid_q;

	// Byte 0 carries K28.5 as a control character
	assign comma_det = (gt_rxdata_i[7:0] == gt_link_pkg::COMMA_CODE) && gt_rxcharisk_i[0];

	////////////////////////////////////////
	// Payload slice
	////////////////////////////////////////

	// Only the lower DWIDTH bits are in use at this data width
	always_ff @(posedge RXUSRCLK) begin
		rx_data_o <= gt_rxdata_i[DWIDTH-1:0];
		rx_charisk_o <= gt_rxcharisk_i[DBYTE-1:0];
		rx_disperr_o <= gt_rxdisperr_i[DBYTE-1:0];
		rx_notintable_o <= gt_rxnotintable_i[DBYTE-1:0];
		rx_comma_o <= comma_det;
	end

	////////////////////////////////////////
	// Valid flag
	////////////////////////////////////////

	always_ff @(posedge RXUSRCLK or posedge reset) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= link_ready_i;
		end
	end

	// A beat stays valid only while the link is still ready, so a lock
	// loss invalidates the word that is already registered
	assign rx_valid_o = valid_q & link_ready_i;

endmodule

// File: source/tx_idle_insert.sv
`timescale 1ns/1ps

module tx_idle_insert #(
	parameter int DWIDTH = 16
) (
	input  logic RXUSRCLK,
	input  logic reset,
	input  logic link_ready_i,
	input  logic [DWIDTH-1:0] tx_data_i,
	input  logic [DWIDTH/8-1:0] tx_charisk_i,
	output logic [gt_link_pkg::RAW_WIDTH-1:0] gt_txdata_o,
	output logic [gt_link_pkg::RAW_BYTES-1:0] gt_txcharisk_o
);

	localparam int DBYTE = DWIDTH / 8;
	localparam int PAD_W = gt_link_pkg::RAW_WIDTH - DWIDTH;
	localparam int PAD_B = gt_link_pkg::RAW_BYTES - DBYTE;

	always_ff @(posedge RXUSRCLK or posedge reset) begin
		if (reset) begin
			gt_txdata_o <= '0;
			gt_txcharisk_o <= '0;
		end else if (link_ready_i) begin
			gt_txdata_o <= {{PAD_W{1'b0}}, tx_data_i};
			gt_txcharisk_o <= {{PAD_B{1'b0}}, tx_charisk_i};
		end else begin
			// Comma in byte 0 keeps the far end aligned while reset runs
			gt_txdata_o <= {{(gt_link_pkg::RAW_WIDTH - 8){1'b0}}, gt_link_pkg::COMMA_CODE};
			gt_txcharisk_o <= {{(gt_link_pkg::RAW_BYTES - 1){1'b0}}, 1'b1};
		end
	end

endmodule
